/* src/rpRegPkg.sv */
package rpRegPkg;

   //////////////////////////////////////////////////
   // Register map
   //////////////////////////////////////////////////

   // Register addresses seen on the host write port
   typedef enum logic [1:0]
   {
      ADDR_CS1 = 2'd0,   // Command and status
      ADDR_DA  = 2'd1,   // Disk address, sector and track
      ADDR_DC  = 2'd2    // Desired cylinder
   } regAddrT;

   //////////////////////////////////////////////////
   // Field layouts
   //////////////////////////////////////////////////

   // Address field widths
   localparam int SECT_W = 6;
   localparam int TRK_W  = 6;
   localparam int CYL_W  = 10;

   // Sector count width in CS1
   localparam int CNT_W  = 8;

   // Disk address word, bits 7..6 and 15..14 read zero
   localparam int DA_SA_LSB = 0;
   localparam int DA_TA_LSB = 8;

   // Command word, opcode low and count above it
   localparam int CS1_FN_LSB  = 0;
   localparam int CS1_CNT_LSB = 4;

   //////////////////////////////////////////////////
   // Structs between blocks
   //////////////////////////////////////////////////

   // One host register write
   typedef struct packed
   {
      logic              valid;
      regAddrT           addr;
      logic [15:0]       data;
   } regWrT;

   // Sector header toward the host
   typedef struct packed
   {
      logic              valid;
      logic [CYL_W-1:0]  cyl;
      logic [TRK_W-1:0]  trk;
      logic [SECT_W-1:0] sect;
   } hdrT;

   // Drive status bits
   typedef struct packed
   {
      logic dry;   // Drive ready
      logic ata;   // Attention, command done
      logic err;   // Illegal function
   } statusT;

endpackage

/* src/rpCmdPkg.sv */
package rpCmdPkg;

   //////////////////////////////////////////////////
   // Command opcodes
   //////////////////////////////////////////////////

   // Function field of CS1
   // Anything not listed here is an illegal function
   typedef enum logic [3:0]
   {
      OP_NOP     = 4'h0,   // No operation, just raises attention
      OP_PRESET  = 4'h1,   // Clear disk address and cylinder
      OP_READHDR = 4'h2    // Read a run of sector headers
   } opcodeT;

   //////////////////////////////////////////////////
   // Controller states
   //////////////////////////////////////////////////

   // Drive is ready only in ST_IDLE
   typedef enum logic [1:0]
   {
      ST_IDLE = 2'd0,   // Ready for a command
      ST_WAIT = 2'd1,   // Waiting for next sector mark
      ST_SEND = 2'd2    // Sector under head, waiting for a credit
   } ctrlStateT;

   // The fourth encoding is unused
   // FSM falls back to ST_IDLE if it ever lands there

endpackage

/* src/rpDiskAddr.sv */
`timescale 1ns/1ps

module rpDiskAddr
#(
   parameter int SECNUM_LAST = 5,
   parameter int TRKNUM_LAST = 2
)
(
   input  logic             clk,
   input  logic             arstN,
   input  rpRegPkg::regWrT  regWr,
   input  logic             dry,
   input  logic             preset,
   input  logic             incSect,
   output logic [15:0]      da,
   output logic             trkWrap
);

   // Geometry limits cut to field width
   localparam logic [rpRegPkg::SECT_W-1:0] SECT_LAST = SECNUM_LAST[rpRegPkg::SECT_W-1:0];
   localparam logic [rpRegPkg::TRK_W-1:0]  TRK_LAST  = TRKNUM_LAST[rpRegPkg::TRK_W-1:0];

   logic [rpRegPkg::SECT_W-1:0] sectQ;
   logic [rpRegPkg::TRK_W-1:0]  trkQ;
   logic                        daWr;
   logic                        sectEnd;
   logic                        trkEnd;

   // Host write to DA, taken only while ready
   assign daWr = regWr.valid && (regWr.addr == rpRegPkg::ADDR_DA) && dry;

   // At or past the last sector / track
   // Out of range values written by the host wrap too
   assign sectEnd = (sectQ >= SECT_LAST);
   assign trkEnd  = (trkQ >= TRK_LAST);

   // Next increment carries out of the last track
   assign trkWrap = sectEnd && trkEnd;

   //////////////////////////////////////////////////
   // Sector address
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         sectQ <= '0;
      end
      else if (preset)
      begin
         sectQ <= '0;
      end
      else if (daWr)
      begin
         sectQ <= regWr.data[rpRegPkg::DA_SA_LSB +: rpRegPkg::SECT_W];
      end
      else if (incSect)
      begin
         // Wrap to sector 0 after the last one
         sectQ <= sectEnd ? '0 : sectQ + 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Track address
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         trkQ <= '0;
      end
      else if (preset)
      begin
         trkQ <= '0;
      end
      else if (daWr)
      begin
         trkQ <= regWr.data[rpRegPkg::DA_TA_LSB +: rpRegPkg::TRK_W];
      end
      else if (incSect && sectEnd)
      begin
         // Step only on sector carry
         trkQ <= trkEnd ? '0 : trkQ + 1'b1;
      end
   end

   // Pack fields, unused bits stay zero
   always_comb
   begin
      da = '0;
      da[rpRegPkg::DA_SA_LSB +: rpRegPkg::SECT_W] = sectQ;
      da[rpRegPkg::DA_TA_LSB +: rpRegPkg::TRK_W]  = trkQ;
   end

   // Stepping keeps the address inside the geometry
   // Also catches an increment racing a host write
   sectRange: assert property (@(posedge clk) disable iff (!arstN)
      incSect && !preset |=> sectQ <= SECT_LAST);

   trkRange: assert property (@(posedge clk) disable iff (!arstN)
      incSect && !preset |=> trkQ <= TRK_LAST);

endmodule

/* src/rpCylAddr.sv */
`timescale 1ns/1ps

module rpCylAddr
#(
   parameter int CYL_LAST = 7
)
(
   input  logic             clk,
   input  logic             arstN,
   input  rpRegPkg::regWrT  regWr,
   input  logic             dry,
   input  logic             preset,
   input  logic             incSect,
   input  logic             trkWrap,
   output logic [15:0]      dc
);

   localparam logic [rpRegPkg::CYL_W-1:0] CYL_MAX = CYL_LAST[rpRegPkg::CYL_W-1:0];

   logic [rpRegPkg::CYL_W-1:0] cylQ;
   logic                       dcWr;
   logic                       step;

   // Host load while ready
   assign dcWr = regWr.valid && (regWr.addr == rpRegPkg::ADDR_DC) && dry;

   // Carry in from the track field
   assign step = incSect && trkWrap;

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         cylQ <= '0;
      end
      else if (preset)
      begin
         cylQ <= '0;
      end
      else if (dcWr)
      begin
         cylQ <= regWr.data[rpRegPkg::CYL_W-1:0];
      end
      else if (step)
      begin
         // Back to cylinder 0 past the last one
         cylQ <= (cylQ >= CYL_MAX) ? '0 : cylQ + 1'b1;
      end
   end

   // Upper bits read zero
   assign dc = {{(16 - rpRegPkg::CYL_W){1'b0}}, cylQ};

   // Controller never steps while the host can write
   noStepOnWrite: assert property (@(posedge clk) disable iff (!arstN)
      dcWr |-> !step);

endmodule

/* src/rpSectorTimer.sv */
`timescale 1ns/1ps

module rpSectorTimer
#(
   parameter int SECTOR_TICKS = 6
)
(
   input  logic clk,
   input  logic arstN,
   input  logic run,
   output logic secMark
);

   // Counter width, at least one bit
   localparam int CNT_W = (SECTOR_TICKS > 1) ? $clog2(SECTOR_TICKS) : 1;
   localparam logic [CNT_W-1:0] TICK_LAST = CNT_W'(SECTOR_TICKS - 1);

   logic [CNT_W-1:0] tickQ;
   logic             lastTick;

   // Final clock of the current sector
   assign lastTick = (tickQ == TICK_LAST);

   //////////////////////////////////////////////////
   // Rotation counter
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         tickQ <= '0;
      end
      else if (!run)
      begin
         // Parked, restart from zero on next run
         tickQ <= '0;
      end
      else if (lastTick)
      begin
         tickQ <= '0;
      end
      else
      begin
         tickQ <= tickQ + 1'b1;
      end
   end

   // One clock pulse per sector under the head
   // First mark comes SECTOR_TICKS clocks after run rises
   assign secMark = run && lastTick;

endmodule

/* src/rpCtrlFsm.sv */
`timescale 1ns/1ps

module rpCtrlFsm
#(
   parameter int MAX_CREDITS = 3
)
(
   input  logic              clk,
   input  logic              arstN,
   input  rpRegPkg::regWrT   regWr,
   input  logic              secMark,
   input  logic              creditRet,
   input  logic [15:0]       da,
   input  logic [15:0]       dc,
   output logic              run,
   output logic              preset,
   output logic              incSect,
   output rpRegPkg::hdrT     hdr,
   output rpRegPkg::statusT  status
);

   localparam int CRD_W = $clog2(MAX_CREDITS + 1);
   localparam logic [CRD_W-1:0] CRD_MAX = CRD_W'(MAX_CREDITS);
   localparam int FN_W = $bits(rpCmdPkg::opcodeT);

   rpCmdPkg::ctrlStateT          stateQ;
   rpCmdPkg::opcodeT             fn;
   logic [rpRegPkg::CNT_W-1:0]   remQ;
   logic [rpRegPkg::CNT_W-1:0]   cnt;
   logic [CRD_W-1:0]             creditQ;
   logic                         ataQ;
   logic                         errQ;
   logic                         donePendQ;
   logic                         hdrValidQ;
   logic [rpRegPkg::CYL_W-1:0]   hdrCylQ;
   logic [rpRegPkg::TRK_W-1:0]   hdrTrkQ;
   logic [rpRegPkg::SECT_W-1:0]  hdrSectQ;
   logic                         dry;
   logic                         cs1Wr;
   logic                         send;

   //////////////////////////////////////////////////
   // Command decode
   //////////////////////////////////////////////////

   // Ready whenever idle
   assign dry   = (stateQ == rpCmdPkg::ST_IDLE);
   assign cs1Wr = regWr.valid && (regWr.addr == rpRegPkg::ADDR_CS1) && dry;
   assign fn    = rpCmdPkg::opcodeT'(regWr.data[rpRegPkg::CS1_FN_LSB +: FN_W]);
   assign cnt   = regWr.data[rpRegPkg::CS1_CNT_LSB +: rpRegPkg::CNT_W];

   // Sector under head and host has room
   assign send    = (stateQ == rpCmdPkg::ST_SEND) && (creditQ != '0);
   assign incSect = send;
   assign run     = !dry;

   // Clears address at the write edge itself
   assign preset  = cs1Wr && (fn == rpCmdPkg::OP_PRESET);

   // Sequencer
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         stateQ <= rpCmdPkg::ST_IDLE;
         remQ   <= '0;
      end
      else
      begin
         case (stateQ)
            rpCmdPkg::ST_IDLE:
            begin
               // Zero count finishes like a NOP
               if (cs1Wr && (fn == rpCmdPkg::OP_READHDR) && (cnt != '0))
               begin
                  remQ   <= cnt;
                  stateQ <= rpCmdPkg::ST_WAIT;
               end
            end
            rpCmdPkg::ST_WAIT:
            begin
               if (secMark)
               begin
                  stateQ <= rpCmdPkg::ST_SEND;
               end
            end
            rpCmdPkg::ST_SEND:
            begin
               // Hold here without credit, timer keeps turning
               if (send)
               begin
                  remQ   <= remQ - 1'b1;
                  stateQ <= (remQ == 1) ? rpCmdPkg::ST_IDLE : rpCmdPkg::ST_WAIT;
               end
            end
            default:
            begin
               stateQ <= rpCmdPkg::ST_IDLE;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Status and credits
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         ataQ      <= 1'b0;
         errQ      <= 1'b0;
         donePendQ <= 1'b0;
      end
      else if (cs1Wr)
      begin
         // New command replaces old attention
         donePendQ <= 1'b0;
         case (fn)
            rpCmdPkg::OP_NOP,
            rpCmdPkg::OP_PRESET:
            begin
               ataQ <= 1'b1;
               errQ <= 1'b0;
            end
            rpCmdPkg::OP_READHDR:
            begin
               ataQ <= (cnt == '0);
               errQ <= 1'b0;
            end
            default:
            begin
               ataQ <= 1'b1;
               errQ <= 1'b1;
            end
         endcase
      end
      else
      begin
         // Attention one clock after the final header
         donePendQ <= send && (remQ == 1);
         if (donePendQ)
         begin
            ataQ <= 1'b1;
         end
      end
   end

   // Host buffer space left
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         creditQ <= CRD_MAX;
      end
      else
      begin
         case ({send, creditRet})
            2'b10:   creditQ <= creditQ - 1'b1;
            2'b01:   creditQ <= creditQ + 1'b1;
            default: creditQ <= creditQ;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Header output
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         hdrValidQ <= 1'b0;
      end
      else
      begin
         hdrValidQ <= send;
      end
   end

   // Address before this edge's increment
   always_ff @(posedge clk)
   begin
      if (send)
      begin
         hdrCylQ  <= dc[rpRegPkg::CYL_W-1:0];
         hdrTrkQ  <= da[rpRegPkg::DA_TA_LSB +: rpRegPkg::TRK_W];
         hdrSectQ <= da[rpRegPkg::DA_SA_LSB +: rpRegPkg::SECT_W];
      end
   end

   assign hdr    = '{valid: hdrValidQ, cyl: hdrCylQ, trk: hdrTrkQ, sect: hdrSectQ};
   assign status = '{dry: dry, ata: ataQ, err: errQ};

   // Host never hands back more than it was given
   creditCap: assert property (@(posedge clk) disable iff (!arstN)
      creditRet && !send |-> creditQ < CRD_MAX);

   // Every header was paid for the cycle before
   hdrHasCredit: assert property (@(posedge clk) disable iff (!arstN)
      hdrValidQ |-> $past(creditQ) != '0);

   // Address step pairs with a header
   incWithHdr: assert property (@(posedge clk) disable iff (!arstN)
      incSect |=> hdrValidQ);

endmodule

/* src/rpDrive.sv */
`timescale 1ns/1ps

module rpDrive
#(
   parameter int SECNUM_LAST  = 5,
   parameter int TRKNUM_LAST  = 2,
   parameter int CYL_LAST     = 7,
   parameter int SECTOR_TICKS = 6,
   parameter int MAX_CREDITS  = 3
)
(
   input  logic              clk,
   input  logic              arstN,
   input  rpRegPkg::regWrT   regWr,
   input  logic              creditRet,
   output rpRegPkg::hdrT     hdr,
   output rpRegPkg::statusT  status,
   output logic [15:0]       da,
   output logic [15:0]       dc
);

   //////////////////////////////////////////////////
   // Internal strobes
   //////////////////////////////////////////////////

   logic run;
   logic secMark;
   logic preset;
   logic incSect;
   logic trkWrap;

   // Sector and track
   rpDiskAddr #(
      .SECNUM_LAST (SECNUM_LAST),
      .TRKNUM_LAST (TRKNUM_LAST)
   ) diskAddr_i (
      .clk     (clk),
      .arstN   (arstN),
      .regWr   (regWr),
      .dry     (status.dry),
      .preset  (preset),
      .incSect (incSect),
      .da      (da),
      .trkWrap (trkWrap)
   );

   // Cylinder, stepped by track carry
   rpCylAddr #(
      .CYL_LAST (CYL_LAST)
   ) cylAddr_i (
      .clk     (clk),
      .arstN   (arstN),
      .regWr   (regWr),
      .dry     (status.dry),
      .preset  (preset),
      .incSect (incSect),
      .trkWrap (trkWrap),
      .dc      (dc)
   );

   // Disk rotation
   rpSectorTimer #(
      .SECTOR_TICKS (SECTOR_TICKS)
   ) sectorTimer_i (
      .clk     (clk),
      .arstN   (arstN),
      .run     (run),
      .secMark (secMark)
   );

   // Command control and header path
   rpCtrlFsm #(
      .MAX_CREDITS (MAX_CREDITS)
   ) ctrlFsm_i (
      .clk       (clk),
      .arstN     (arstN),
      .regWr     (regWr),
      .secMark   (secMark),
      .creditRet (creditRet),
      .da        (da),
      .dc        (dc),
      .run       (run),
      .preset    (preset),
      .incSect   (incSect),
      .hdr       (hdr),
      .status    (status)
   );

endmodule

/* testbench/rpDriveTb.sv */
`timescale 1ns/1ps

module rpDriveTb;

   // Geometry, same values as the drive defaults
   localparam int SECNUM_LAST  = 5;
   localparam int TRKNUM_LAST  = 2;
   localparam int CYL_LAST     = 7;
   localparam int SECTOR_TICKS = 6;
   localparam int MAX_CREDITS  = 3;

   // Header runs
   localparam int LONG_CNT  = 27;
   localparam int SHORT_CNT = 10;

   // Four short tests count as zero-header runs
   localparam int TEST_SECTORS = (LONG_CNT + 2) + (SHORT_CNT + 2) + 4 * (0 + 2);
   localparam int WATCHDOG_NS  = TEST_SECTORS * SECTOR_TICKS * 40 * 4;

   logic              clk = 1'b0;
   logic              arstN;
   rpRegPkg::regWrT   regWr;
   logic              creditRet;
   rpRegPkg::hdrT     hdr;
   rpRegPkg::statusT  status;
   logic [15:0]       da;
   logic [15:0]       dc;

   // Error tallies
   int valueErrs = 0;
   int otherErrs = 0;

   // Reference address of the next header
   int expSect = 0;
   int expTrk  = 0;
   int expCyl  = 0;
   bit trackOn = 1'b0;

   // Host side bookkeeping
   int          hdrWanted = 0;
   int          rxCount   = 0;
   int          retCount  = 0;
   int          holdLeft  = 0;
   logic [31:0] rngState  = 32'd41210;

   rpDrive #(
      .SECNUM_LAST  (SECNUM_LAST),
      .TRKNUM_LAST  (TRKNUM_LAST),
      .CYL_LAST     (CYL_LAST),
      .SECTOR_TICKS (SECTOR_TICKS),
      .MAX_CREDITS  (MAX_CREDITS)
   ) rpDrive_i (
      .clk       (clk),
      .arstN     (arstN),
      .regWr     (regWr),
      .creditRet (creditRet),
      .hdr       (hdr),
      .status    (status),
      .da        (da),
      .dc        (dc)
   );

   // 40 ns period
   always #20 clk = ~clk;

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   function automatic logic [31:0] nextRandom(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // DA word from sector and track
   function automatic logic [15:0] packDa(input int sect, input int trk);
      return 16'(sect << rpRegPkg::DA_SA_LSB) | 16'(trk << rpRegPkg::DA_TA_LSB);
   endfunction

   // CS1 word, opcode plus sector count
   function automatic logic [15:0] cmdWord(input logic [3:0] fn, input int cnt);
      return (16'(cnt) << rpRegPkg::CS1_CNT_LSB) | (16'(fn) << rpRegPkg::CS1_FN_LSB);
   endfunction

   task automatic compareValue(input string name, input logic [15:0] expVal,
                               input logic [15:0] actVal);
      assert (actVal === expVal)
      else
      begin
         valueErrs++;
         $display("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expVal, actVal);
      end
   endtask

   // Sector, then track, then cylinder carry
   task automatic stepAddress();
      if (expSect == SECNUM_LAST)
      begin
         expSect = 0;
         if (expTrk == TRKNUM_LAST)
         begin
            expTrk = 0;
            expCyl = (expCyl == CYL_LAST) ? 0 : expCyl + 1;
         end
         else
         begin
            expTrk = expTrk + 1;
         end
      end
      else
      begin
         expSect = expSect + 1;
      end
   endtask

   // Per-cycle host work at the falling edge
   task automatic observe();
      if (hdr.valid)
      begin
         assert (rxCount < hdrWanted)
         else
         begin
            otherErrs++;
            $display("%0t ns: a header arrived that no command asked for", $time);
         end
         compareValue("hdr.cyl", 16'(expCyl), 16'(hdr.cyl));
         compareValue("hdr.trk", 16'(expTrk), 16'(hdr.trk));
         compareValue("hdr.sect", 16'(expSect), 16'(hdr.sect));
         rxCount++;
         stepAddress();
      end
      // Address follows the reference every cycle
      if (trackOn)
      begin
         compareValue("da", packDa(expSect, expTrk), da);
         compareValue("dc", 16'(expCyl), dc);
      end
      // Credit return after a random hold of 0 to 7 cycles
      creditRet = 1'b0;
      if (holdLeft > 0)
      begin
         holdLeft--;
      end
      else if (retCount < rxCount)
      begin
         creditRet = 1'b1;
         retCount++;
         rngState = nextRandom(rngState);
         holdLeft = int'(rngState[2:0]);
      end
      assert (rxCount - retCount <= MAX_CREDITS)
      else
      begin
         otherErrs++;
         $display("%0t ns: host holds %0d unreturned headers, more than its %0d credits",
                  $time, rxCount - retCount, MAX_CREDITS);
      end
   endtask

   task automatic tick();
      @(negedge clk);
      observe();
   endtask

   // One-cycle register write, returns when it shows
   task automatic writeReg(input rpRegPkg::regAddrT addr, input logic [15:0] data);
      regWr.valid = 1'b1;
      regWr.addr = addr;
      regWr.data = data;
      tick();
      regWr = '0;
   endtask

   task automatic runReadHdr(input int count, input bit busyWrites);
      hdrWanted = hdrWanted + count;
      writeReg(rpRegPkg::ADDR_CS1, cmdWord(rpCmdPkg::OP_READHDR, count));
      compareValue("status.dry", 16'd0, 16'(status.dry));
      compareValue("status.ata", 16'd0, 16'(status.ata));
      if (busyWrites)
      begin
         // Busy, all three get dropped
         writeReg(rpRegPkg::ADDR_DA, 16'h0203);
         writeReg(rpRegPkg::ADDR_DC, 16'h0001);
         writeReg(rpRegPkg::ADDR_CS1, cmdWord(rpCmdPkg::OP_PRESET, 0));
         compareValue("status.ata", 16'd0, 16'(status.ata));
      end
      while (!status.dry)
         tick();
      // Attention trails ready by a cycle
      compareValue("status.ata", 16'd0, 16'(status.ata));
      tick();
      compareValue("status.dry", 16'd1, 16'(status.dry));
      compareValue("status.ata", 16'd1, 16'(status.ata));
      compareValue("status.err", 16'd0, 16'(status.err));
      assert (rxCount == hdrWanted)
      else
      begin
         otherErrs++;
         $display("%0t ns: READHDR of %0d ended %0d headers short",
                  $time, count, hdrWanted - rxCount);
      end
      compareValue("da", packDa(expSect, expTrk), da);
      compareValue("dc", 16'(expCyl), dc);
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial
   begin
      arstN = 1'b0;
      regWr = '0;
      creditRet = 1'b0;
      repeat (2) tick();
      arstN = 1'b1;
      tick();

      // Idle after reset
      compareValue("hdr.valid", 16'd0, 16'(hdr.valid));
      compareValue("status.dry", 16'd1, 16'(status.dry));
      compareValue("status.ata", 16'd0, 16'(status.ata));
      compareValue("status.err", 16'd0, 16'(status.err));
      compareValue("da", 16'd0, da);
      compareValue("dc", 16'd0, dc);

      // Unused DA bits set, must read back zero
      writeReg(rpRegPkg::ADDR_DA, 16'hC1C4);
      compareValue("da", 16'h0104, da);
      writeReg(rpRegPkg::ADDR_DC, 16'hFC06);
      compareValue("dc", 16'h0006, dc);

      // PRESET
      writeReg(rpRegPkg::ADDR_CS1, cmdWord(rpCmdPkg::OP_PRESET, 0));
      compareValue("da", 16'd0, da);
      compareValue("dc", 16'd0, dc);
      compareValue("status.ata", 16'd1, 16'(status.ata));
      compareValue("status.err", 16'd0, 16'(status.err));

      // Start two sectors before a track carry on cylinder 6
      // 27 headers run through cylinder 7 and wrap to 0
      writeReg(rpRegPkg::ADDR_DA, packDa(4, 1));
      writeReg(rpRegPkg::ADDR_DC, 16'd6);
      expSect = 4;
      expTrk = 1;
      expCyl = 6;
      trackOn = 1'b1;
      // Host sits on its credits until the drive has to stall
      holdLeft = (MAX_CREDITS + 2) * SECTOR_TICKS;
      runReadHdr(LONG_CNT, 1'b1);

      // Carry on from where the long run stopped
      runReadHdr(SHORT_CNT, 1'b0);

      // Illegal opcode, no header may show up
      writeReg(rpRegPkg::ADDR_CS1, cmdWord(4'hF, 1));
      compareValue("status.err", 16'd1, 16'(status.err));
      compareValue("status.ata", 16'd1, 16'(status.ata));
      compareValue("status.dry", 16'd1, 16'(status.dry));
      repeat (2 * SECTOR_TICKS) tick();

      // Valid NOP clears the error
      writeReg(rpRegPkg::ADDR_CS1, cmdWord(rpCmdPkg::OP_NOP, 0));
      compareValue("status.err", 16'd0, 16'(status.err));
      compareValue("status.ata", 16'd1, 16'(status.ata));
      repeat (4) tick();

      $display("Summary: %0d value mismatches, %0d protocol failures", valueErrs, otherErrs);
      if ((valueErrs == 0) && (otherErrs == 0))
      begin
         $display("=== PASS ===");
      end
      else
      begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Watchdog
   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

/* project.f */
src/rpRegPkg.sv
src/rpCmdPkg.sv
src/rpDiskAddr.sv
src/rpCylAddr.sv
src/rpSectorTimer.sv
src/rpCtrlFsm.sv
src/rpDrive.sv
testbench/rpDriveTb.sv

/* Makefile */
# Verilator build and run of the drive testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run check clean

all: check

compile:
	verilator --binary --timing --assert -Mdir $(OBJ_DIR) --top-module rpDriveTb -f project.f

run: compile
	./$(OBJ_DIR)/VrpDriveTb > $(LOG) 2>&1; cat $(LOG)

# Pass only when the log holds the pass line
check: run
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
